//--- common/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    localparam int REG_BIT    = 16;
    localparam int NUM_REG    = 16;
    localparam int REG_ID_BIT = 4;
    localparam int IMM_BIT    = 8;

    // Code 7 is reserved and never issued to a unit
    typedef enum logic [2:0] {
        OP_ST      = 3'd0,
        OP_CMP_GT  = 3'd1,
        OP_ADD_IMM = 3'd2,
        OP_ADD     = 3'd3,
        OP_SHL     = 3'd4,
        OP_SHR     = 3'd5,
        OP_MUL     = 3'd6
    } op_e;

    // Stores use the register form with src0 as address and src1 as data
    typedef struct packed {
        logic [REG_ID_BIT-1:0] dst;
        logic [REG_ID_BIT-1:0] src0;
        logic [REG_ID_BIT-1:0] src1;
        logic [3:0]            pad;
    } reg_form_t;

    typedef struct packed {
        logic [REG_ID_BIT-1:0] dst;
        logic [REG_ID_BIT-1:0] src0;
        logic [IMM_BIT-1:0]    imm;
    } imm_form_t;

    typedef union packed {
        reg_form_t rform;
        imm_form_t iform;
    } inst_body_u;

    typedef struct packed {
        op_e        op;
        inst_body_u body;
    } inst_t;

    typedef struct packed {
        op_e                   op;
        logic [REG_ID_BIT-1:0] dst;
        logic [REG_BIT-1:0]    a;
        logic [REG_BIT-1:0]    b;
    } exec_req_t;

    typedef struct packed {
        logic                  vld;
        logic [REG_ID_BIT-1:0] dst;
        logic [REG_BIT-1:0]    data;
    } wb_t;

    typedef struct packed {
        logic [REG_BIT-1:0] addr;
        logic [REG_BIT-1:0] data;
    } store_t;

endpackage

`default_nettype wire

//--- exec/alu_unit.sv
`timescale 1ns/1ps
`default_nettype none

module alu_unit
    import cpu_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      req_vld,
    input  exec_req_t req,
    output wb_t       wb
);

    logic [REG_BIT-1:0]    result;
    logic                  wb_vld_q;
    logic [REG_ID_BIT-1:0] wb_dst_q;
    logic [REG_BIT-1:0]    wb_data_q;

    // Shift amount is the low 4 bits of b, compare is unsigned
    always_comb begin
        case (req.op)
            OP_ADD, OP_ADD_IMM: result = req.a + req.b;
            OP_SHL:             result = req.a << req.b[3:0];
            OP_SHR:             result = req.a >> req.b[3:0];
            OP_CMP_GT:          result = {{(REG_BIT - 1){1'b0}}, req.a > req.b};
            default:            result = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_vld_q <= 1'b0;
        end else begin
            wb_vld_q <= req_vld;
        end
    end

    always_ff @(posedge clk) begin
        if (req_vld) begin
            wb_dst_q  <= req.dst;
            wb_data_q <= result;
        end
    end

    assign wb.vld  = wb_vld_q;
    assign wb.dst  = wb_dst_q;
    assign wb.data = wb_data_q;

endmodule

`default_nettype wire

//--- exec/mul_unit.sv
`timescale 1ns/1ps
`default_nettype none

module mul_unit
    import cpu_pkg::*;
#(
    parameter int MUL_STAGES = 3
) (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      req_vld,
    input  exec_req_t req,
    output wb_t       wb
);

    logic                  vld_q  [MUL_STAGES];
    logic [REG_ID_BIT-1:0] dst_q  [MUL_STAGES];
    logic [REG_BIT-1:0]    data_q [MUL_STAGES];
    logic [REG_BIT-1:0]    product;

    // Only the low half of the product is kept
    assign product = req.a * req.b;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < MUL_STAGES; i++) begin
                vld_q[i] <= 1'b0;
            end
        end else begin
            vld_q[0] <= req_vld;
            for (int i = 1; i < MUL_STAGES; i++) begin
                vld_q[i] <= vld_q[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        dst_q[0]  <= req.dst;
        data_q[0] <= product;
        for (int i = 1; i < MUL_STAGES; i++) begin
            dst_q[i]  <= dst_q[i-1];
            data_q[i] <= data_q[i-1];
        end
    end

    assign wb.vld  = vld_q[MUL_STAGES-1];
    assign wb.dst  = dst_q[MUL_STAGES-1];
    assign wb.data = data_q[MUL_STAGES-1];

endmodule

`default_nettype wire

//--- rtl/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file
    import cpu_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [REG_ID_BIT-1:0] rd_addr0,
    input  logic [REG_ID_BIT-1:0] rd_addr1,
    input  logic [REG_ID_BIT-1:0] rd_addr2,
    output logic [REG_BIT-1:0]    rd_data0,
    output logic [REG_BIT-1:0]    rd_data1,
    output logic [REG_BIT-1:0]    rd_data2,
    input  wb_t                   wb0,
    input  wb_t                   wb1
);

    logic [REG_BIT-1:0] regs [NUM_REG];

    // Both ports may write in one cycle, never to the same register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REG; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_REG; i++) begin
                if (wb0.vld && wb0.dst == REG_ID_BIT'(i)) begin
                    regs[i] <= wb0.data;
                end else if (wb1.vld && wb1.dst == REG_ID_BIT'(i)) begin
                    regs[i] <= wb1.data;
                end
            end
        end
    end

    assign rd_data0 = regs[rd_addr0];
    assign rd_data1 = regs[rd_addr1];
    assign rd_data2 = regs[rd_addr2];

endmodule

`default_nettype wire

//--- rtl/store_queue.sv
`timescale 1ns/1ps
`default_nettype none

module store_queue
    import cpu_pkg::*;
#(
    parameter int STQ_DEPTH = 4
) (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   push,
    input  store_t entry,
    output logic   full,
    output logic   empty,
    output logic   out_vld,
    input  logic   out_rdy,
    output store_t out
);

    localparam int PTR_BIT = (STQ_DEPTH > 1) ? $clog2(STQ_DEPTH) : 1;
    localparam int CNT_BIT = $clog2(STQ_DEPTH + 1);

    store_t             mem [STQ_DEPTH];
    logic [PTR_BIT-1:0] wr_ptr;
    logic [PTR_BIT-1:0] rd_ptr;
    logic [CNT_BIT-1:0] count;
    logic               do_push;
    logic               do_pop;

    assign full    = count == CNT_BIT'(STQ_DEPTH);
    assign empty   = count == '0;
    assign out_vld = !empty;
    assign out     = mem[rd_ptr];
    assign do_push = push && !full;
    assign do_pop  = out_vld && out_rdy;

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= entry;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_BIT'(STQ_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            // Head stays put while the memory port is stalled
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_BIT'(STQ_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/issue_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module issue_ctrl
    import cpu_pkg::*;
#(
    parameter int MUL_STAGES = 3
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  inst_vld,
    output logic                  inst_rdy,
    input  logic                  inst_last,
    input  inst_t                 inst,
    output logic [REG_ID_BIT-1:0] rd_addr0,
    output logic [REG_ID_BIT-1:0] rd_addr1,
    output logic [REG_ID_BIT-1:0] rd_addr2,
    input  logic [REG_BIT-1:0]    rd_data0,
    input  logic [REG_BIT-1:0]    rd_data1,
    input  logic [REG_BIT-1:0]    rd_data2,
    output logic                  alu_req,
    output logic                  mul_req,
    output exec_req_t             req,
    output logic                  stq_push,
    output store_t                stq_entry,
    input  logic                  stq_full,
    input  logic                  stq_empty,
    input  wb_t                   alu_wb,
    input  wb_t                   mul_wb,
    output logic                  exec_finish
);

    logic                  is_imm;
    logic                  is_st;
    logic                  is_mul;
    logic                  is_alu;
    logic [REG_ID_BIT-1:0] dst;
    logic [REG_ID_BIT-1:0] src0;
    logic [REG_ID_BIT-1:0] src1;
    logic [NUM_REG-1:0]    pending;
    logic [NUM_REG-1:0]    wb_clear;
    logic                  hazard;
    logic                  issue;
    logic                  last_issued;
    logic                  finish_q;

    if (MUL_STAGES < 1) begin : g_bad_mul_depth
        $error("MUL_STAGES must be at least 1");
    end

    always_comb begin
        is_imm = inst.op == OP_ADD_IMM;
        is_st  = inst.op == OP_ST;
        is_mul = inst.op == OP_MUL;
        is_alu = inst.op inside {OP_CMP_GT, OP_ADD_IMM, OP_ADD, OP_SHL, OP_SHR};
        if (is_imm) begin
            dst  = inst.body.iform.dst;
            src0 = inst.body.iform.src0;
        end else begin
            dst  = inst.body.rform.dst;
            src0 = inst.body.rform.src0;
        end
        src1 = inst.body.rform.src1;
    end

    // No bypass, so a register cleared this cycle still blocks until the next
    always_comb begin
        hazard = pending[src0];
        if (!is_imm) begin
            hazard = hazard | pending[src1];
        end
        if (!is_st) begin
            hazard = hazard | pending[dst];
        end
    end

    assign inst_rdy = !last_issued && !hazard && !(is_st && stq_full);
    assign issue    = inst_vld && inst_rdy;

    assign alu_req  = issue && is_alu;
    assign mul_req  = issue && is_mul;
    assign stq_push = issue && is_st;

    // Port 1 carries the store address, port 2 the store data
    assign rd_addr0 = src0;
    assign rd_addr1 = is_st ? src0 : src1;
    assign rd_addr2 = src1;

    assign req.op  = inst.op;
    assign req.dst = dst;
    assign req.a   = rd_data0;
    assign req.b   = is_imm ? {{(REG_BIT - IMM_BIT){1'b0}}, inst.body.iform.imm} : rd_data1;

    assign stq_entry.addr = rd_data1;
    assign stq_entry.data = rd_data2;

    always_comb begin
        wb_clear = '0;
        if (alu_wb.vld) begin
            wb_clear[alu_wb.dst] = 1'b1;
        end
        if (mul_wb.vld) begin
            wb_clear[mul_wb.dst] = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending     <= '0;
            last_issued <= 1'b0;
            finish_q    <= 1'b0;
        end else begin
            pending <= pending & ~wb_clear;
            if (issue && (is_alu || is_mul)) begin
                pending[dst] <= 1'b1;
            end
            if (issue && inst_last) begin
                last_issued <= 1'b1;
            end
            if (last_issued && pending == '0 && stq_empty) begin
                finish_q <= 1'b1;
            end
        end
    end

    assign exec_finish = finish_q;

endmodule

`default_nettype wire

//--- rtl/cpu_core.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_core
    import cpu_pkg::*;
#(
    parameter int MUL_STAGES = 3,
    parameter int STQ_DEPTH  = 4
) (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   inst_vld,
    output logic   inst_rdy,
    input  logic   inst_last,
    input  inst_t  inst,
    output logic   write_mem_vld,
    input  logic   write_mem_rdy,
    output store_t write_mem,
    output logic   exec_finish
);

    logic [REG_ID_BIT-1:0] rd_addr0;
    logic [REG_ID_BIT-1:0] rd_addr1;
    logic [REG_ID_BIT-1:0] rd_addr2;
    logic [REG_BIT-1:0]    rd_data0;
    logic [REG_BIT-1:0]    rd_data1;
    logic [REG_BIT-1:0]    rd_data2;
    logic                  alu_req;
    logic                  mul_req;
    exec_req_t             req;
    logic                  stq_push;
    store_t                stq_entry;
    logic                  stq_full;
    logic                  stq_empty;
    wb_t                   alu_wb;
    wb_t                   mul_wb;

    issue_ctrl #(
        .MUL_STAGES (MUL_STAGES)
    ) i_issue_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .inst_vld    (inst_vld),
        .inst_rdy    (inst_rdy),
        .inst_last   (inst_last),
        .inst        (inst),
        .rd_addr0    (rd_addr0),
        .rd_addr1    (rd_addr1),
        .rd_addr2    (rd_addr2),
        .rd_data0    (rd_data0),
        .rd_data1    (rd_data1),
        .rd_data2    (rd_data2),
        .alu_req     (alu_req),
        .mul_req     (mul_req),
        .req         (req),
        .stq_push    (stq_push),
        .stq_entry   (stq_entry),
        .stq_full    (stq_full),
        .stq_empty   (stq_empty),
        .alu_wb      (alu_wb),
        .mul_wb      (mul_wb),
        .exec_finish (exec_finish)
    );

    reg_file i_reg_file (
        .clk      (clk),
        .rst_n    (rst_n),
        .rd_addr0 (rd_addr0),
        .rd_addr1 (rd_addr1),
        .rd_addr2 (rd_addr2),
        .rd_data0 (rd_data0),
        .rd_data1 (rd_data1),
        .rd_data2 (rd_data2),
        .wb0      (alu_wb),
        .wb1      (mul_wb)
    );

    alu_unit i_alu_unit (
        .clk     (clk),
        .rst_n   (rst_n),
        .req_vld (alu_req),
        .req     (req),
        .wb      (alu_wb)
    );

    mul_unit #(
        .MUL_STAGES (MUL_STAGES)
    ) i_mul_unit (
        .clk     (clk),
        .rst_n   (rst_n),
        .req_vld (mul_req),
        .req     (req),
        .wb      (mul_wb)
    );

    store_queue #(
        .STQ_DEPTH (STQ_DEPTH)
    ) i_store_queue (
        .clk     (clk),
        .rst_n   (rst_n),
        .push    (stq_push),
        .entry   (stq_entry),
        .full    (stq_full),
        .empty   (stq_empty),
        .out_vld (write_mem_vld),
        .out_rdy (write_mem_rdy),
        .out     (write_mem)
    );

endmodule

`default_nettype wire

//--- dv/cpu_core_assert.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_core_assert
    import cpu_pkg::*;
(
    input logic   clk,
    input logic   rst_n,
    input logic   write_mem_vld,
    input logic   write_mem_rdy,
    input store_t write_mem,
    input logic   exec_finish
);

    // A stalled write stays on the port until the memory takes it
    a_mem_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        write_mem_vld && !write_mem_rdy |=> write_mem_vld && $stable(write_mem)
    ) else $error("write_mem changed while the memory port was stalled");

    a_finish_sticky: assert property (
        @(posedge clk) disable iff (!rst_n)
        exec_finish |=> exec_finish
    ) else $error("exec_finish fell after it had risen");

    // Once finished, the store queue has drained
    a_finish_drained: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(exec_finish && write_mem_vld)
    ) else $error("exec_finish is high while a memory write is pending");

endmodule

bind cpu_core cpu_core_assert i_cpu_core_assert (
    .clk           (clk),
    .rst_n         (rst_n),
    .write_mem_vld (write_mem_vld),
    .write_mem_rdy (write_mem_rdy),
    .write_mem     (write_mem),
    .exec_finish   (exec_finish)
);

`default_nettype wire

//--- dv/cpu_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_core_tb
    import cpu_pkg::*;
();

    localparam int          CLK_PERIOD     = 10;
    localparam int          DRIVE_DELAY    = 1;
    localparam int          RESET_CYCLES   = 5;
    localparam int          TIMEOUT_FACTOR = 60;
    localparam int          MAX_WORDS      = 64;
    localparam int          STRETCH_AT     = 20;
    localparam int          STRETCH_LEN    = 20;
    localparam logic [15:0] LFSR_SEED      = 16'd10796;
    localparam string       PATTERN_FILE   = "dv/cpu_core_patterns.mem";

    logic   clk;
    logic   rst_n;
    logic   inst_vld;
    logic   inst_rdy;
    logic   inst_last;
    inst_t  inst;
    logic   write_mem_vld;
    logic   write_mem_rdy;
    store_t write_mem;
    logic   exec_finish;

    logic [31:0] pat_words [MAX_WORDS];
    inst_t       inst_list [MAX_WORDS];
    store_t      exp_list  [MAX_WORDS];
    int          n_inst;
    int          n_exp;
    int          exp_idx        = 0;
    int          accepted_count = 0;
    int          error_count    = 0;
    int          cycle_count    = 0;
    int          timeout_limit  = 0;
    logic        finish_seen    = 1'b0;

    cpu_core i_cpu_core (
        .clk           (clk),
        .rst_n         (rst_n),
        .inst_vld      (inst_vld),
        .inst_rdy      (inst_rdy),
        .inst_last     (inst_last),
        .inst          (inst),
        .write_mem_vld (write_mem_vld),
        .write_mem_rdy (write_mem_rdy),
        .write_mem     (write_mem),
        .exec_finish   (exec_finish)
    );

    // Taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        logic feedback;
        feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
        return {state[14:0], feedback};
    endfunction

    task automatic load_patterns();
        int i;
        for (i = 0; i < MAX_WORDS; i++) begin
            pat_words[i] = '0;
        end
        $readmemh(PATTERN_FILE, pat_words);
        n_inst = int'(pat_words[0][31:16]);
        n_exp  = int'(pat_words[0][15:0]);
        if (n_inst == 0 || 1 + n_inst + n_exp > MAX_WORDS) begin
            $display("Pattern file %s is missing or holds bad counts", PATTERN_FILE);
            error_count++;
            n_inst = 0;
            n_exp  = 0;
        end else begin
            for (i = 0; i < n_inst; i++) begin
                inst_list[i] = pat_words[1 + i][18:0];
            end
            for (i = 0; i < n_exp; i++) begin
                exp_list[i] = pat_words[1 + n_inst + i];
            end
        end
    endtask

    // Handshake is decided at the falling edge, where all inputs are settled
    task automatic send_inst(input inst_t word, input logic last);
        inst_vld  = 1'b1;
        inst      = word;
        inst_last = last;
        @(negedge clk);
        while (!inst_rdy) begin
            @(negedge clk);
        end
        @(posedge clk);
        #DRIVE_DELAY;
        accepted_count++;
    endtask

    task automatic check_write(input store_t got);
        store_t want;
        if (exp_idx >= n_exp) begin
            $display("Extra write at %0t to address 0x%04h beyond the expected list",
                     $time, got.addr);
            error_count++;
        end else begin
            want = exp_list[exp_idx];
            if (got.addr != want.addr) begin
                $display("ERROR %0t: write_mem.addr expected 0x%04h actual 0x%04h",
                         $time, want.addr, got.addr);
                error_count++;
            end
            if (got.data != want.data) begin
                $display("ERROR %0t: write_mem.data expected 0x%04h actual 0x%04h",
                         $time, want.data, got.data);
                error_count++;
            end
            exp_idx++;
        end
    endtask

    task automatic print_counts();
        $display("Writes checked: %0d of %0d, errors: %0d", exp_idx, n_exp, error_count);
    endtask

    initial begin : clock_gen
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2);
            clk = ~clk;
        end
    end

    // Random back-pressure with one long stall that fills the store queue
    initial begin : ready_driver
        logic [15:0] lfsr;
        int          stretch_left;
        logic        stretch_done;
        lfsr          = LFSR_SEED;
        stretch_left  = 0;
        stretch_done  = 1'b0;
        write_mem_rdy = 1'b0;
        @(posedge rst_n);
        forever begin
            @(posedge clk);
            if (!stretch_done && accepted_count >= STRETCH_AT) begin
                stretch_done = 1'b1;
                stretch_left = STRETCH_LEN;
            end
            #DRIVE_DELAY;
            if (stretch_left > 0) begin
                write_mem_rdy = 1'b0;
                stretch_left--;
            end else begin
                lfsr          = lfsr_step(lfsr);
                write_mem_rdy = lfsr[0];
            end
        end
    end

    always @(negedge clk) begin
        if (rst_n) begin
            if (write_mem_vld && write_mem_rdy) begin
                check_write(write_mem);
            end
            if (exec_finish && !finish_seen) begin
                finish_seen = 1'b1;
                if (exp_idx != n_exp) begin
                    $display("exec_finish rose after only %0d of %0d expected writes",
                             exp_idx, n_exp);
                    error_count++;
                end
            end else if (finish_seen && !exec_finish) begin
                $display("exec_finish fell at %0t after it had risen", $time);
                error_count++;
            end
        end
    end

    always @(posedge clk) begin
        if (rst_n && timeout_limit > 0) begin
            cycle_count++;
            if (cycle_count > timeout_limit) begin
                $display("Timeout after %0d cycles without exec_finish", timeout_limit);
                error_count++;
                print_counts();
                $display("Simulation finished: FAIL");
                $finish;
            end
        end
    end

    initial begin : main
        int i;
        rst_n     = 1'b0;
        inst_vld  = 1'b0;
        inst_last = 1'b0;
        inst      = '0;
        load_patterns();
        if (n_inst > 0) begin
            timeout_limit = TIMEOUT_FACTOR * n_inst;
            repeat (RESET_CYCLES) @(posedge clk);
            #DRIVE_DELAY;
            rst_n = 1'b1;
            @(negedge clk);
            if (write_mem_vld !== 1'b0) begin
                $display("ERROR %0t: write_mem_vld expected 0 actual %b", $time, write_mem_vld);
                error_count++;
            end
            if (exec_finish !== 1'b0) begin
                $display("ERROR %0t: exec_finish expected 0 actual %b", $time, exec_finish);
                error_count++;
            end
            @(posedge clk);
            #DRIVE_DELAY;
            for (i = 0; i < n_inst; i++) begin
                send_inst(inst_list[i], i == n_inst - 1);
            end
            inst_vld  = 1'b0;
            inst_last = 1'b0;
            while (!finish_seen) begin
                @(negedge clk);
            end
            // The monitor keeps watching exec_finish over these cycles
            repeat (10) @(negedge clk);
        end
        print_counts();
        if (error_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/cpu_core_patterns.mem
// Word 0 holds the instruction count (upper 16 bits) and expected write count (lower 16 bits)
// Then one instruction {op, body} per word, then the expected writes as {addr, data}
0021000E
21005  // ADD_IMM r1 = r0 + 0x05
220C8  // ADD_IMM r2 = r0 + 0xC8
33120  // ADD r3 = r1 + r2
2A010  // ADD_IMM r10 = r0 + 0x10
00A30  // ST [r10] = r3
44110  // SHL r4 = r1 << r1
2BA01  // ADD_IMM r11 = r10 + 1
00B40  // ST [r11] = r4
55210  // SHR r5 = r2 >> r1
2CB01  // ADD_IMM r12 = r11 + 1
00C50  // ST [r12] = r5
16210  // CMP_GT r6 = r2 > r1
17120  // CMP_GT r7 = r1 > r2
2DC01  // ADD_IMM r13 = r12 + 1
00D60  // ST [r13] = r6
2ED01  // ADD_IMM r14 = r13 + 1
00E70  // ST [r14] = r7
68320  // MUL r8 = r3 * r2
69820  // MUL r9 = r8 * r2
3F910  // ADD r15 = r9 + r1
2AE01  // ADD_IMM r10 = r14 + 1
00A80  // ST [r10] = r8
2BA01  // ADD_IMM r11 = r10 + 1
00B90  // ST [r11] = r9
2CB01  // ADD_IMM r12 = r11 + 1
00CF0  // ST [r12] = r15
00120  // ST [r1] = r2
00230  // ST [r2] = r3
00310  // ST [r3] = r1
004F0  // ST [r4] = r15
00090  // ST [r0] = r9
211FF  // ADD_IMM r1 = r1 + 0xFF
00010  // ST [r0] = r1
// Expected memory writes in program order
001000CD 001100A0 00120006 00130001
00140000 0015A028 00161F40 00171F45
000500C8 00C800CD 00CD0005 00A01F45
00001F40 00000104

//--- vlog.f
common/cpu_pkg.sv
exec/alu_unit.sv
exec/mul_unit.sv
rtl/reg_file.sv
rtl/store_queue.sv
rtl/issue_ctrl.sv
rtl/cpu_core.sv
dv/cpu_core_assert.sv
dv/cpu_core_tb.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module cpu_core_tb \
    -f vlog.f -o cpu_core_sim || { echo "Build failed"; exit 1; }

out=$(./obj_dir/cpu_core_sim)
echo "$out"
echo "$out" | grep -qxF "Simulation finished: PASS" && echo "Run passed" \
    || { echo "Run failed"; exit 1; }
